// ==== Bender.yml ====
package:
  name: periph_subsys

sources:
  - hw/periph_pkg.sv
  - hw/apb_decoder.sv
  - hw/cfg_regs.sv
  - hw/reset_gen.sv
  - hw/int_ctrl.sv
  - hw/periph_subsys.sv
  - target: test
    files:
      - testbench/periph_subsys_tb.sv

// ==== hw/apb_decoder.sv ====
`timescale 1ns/1ps

module apb_decoder import periph_pkg::*; (
    input                           psel,
    input                           penable,
    input        [APB_ADDR_W-1:0]   paddr,

    // read words from the register blocks
    input        [APB_DATA_W-1:0]   cfg_rdata,
    input        [APB_DATA_W-1:0]   intc_rdata,

    // block selects and shared offset
    output logic                    cfg_sel,
    output logic                    intc_sel,
    output logic [OFFSET_W-1:0]     offset,

    // response to the apb master
    output logic [APB_DATA_W-1:0]   prdata,
    output logic                    pready,
    output logic                    pslverr
);

logic [REGION_W-1:0] region;

assign region = paddr[REGION_LSB +: REGION_W];
assign offset = paddr[OFFSET_W-1:0];

// no wait states, every access cycle completes
assign pready = psel & penable;

always_comb begin
    cfg_sel  = 1'b0;
    intc_sel = 1'b0;
    prdata   = '0;
    pslverr  = 1'b0;
    case (region)
        REGION_CFG: begin
            cfg_sel = psel;
            prdata  = cfg_rdata;
        end
        REGION_INTC: begin
            intc_sel = psel;
            prdata   = intc_rdata;
        end
        default: begin
            // unmapped region, no select so nothing gets written
            pslverr = psel & penable;
        end
    endcase
end

endmodule

// ==== hw/cfg_regs.sv ====
`timescale 1ns/1ps

module cfg_regs import periph_pkg::*; (
    input                           clk,
    input                           reset,

    // apb slave side, already decoded
    input                           sel,
    input                           penable,
    input                           pwrite,
    input        [OFFSET_W-1:0]     offset,
    input        [APB_STRB_W-1:0]   pstrb,
    input        [APB_DATA_W-1:0]   pwdata,
    output logic [APB_DATA_W-1:0]   rdata,

    // configuration outputs
    output logic [31:0]             ddr_offset,
    output logic [31:0]             boot_vec,
    output logic                    core_reset
);

logic wr_en;

// writes land on the edge that ends the access cycle
assign wr_en = sel & penable & pwrite;

// main reset only, so a warm reset leaves these alone
always_ff @(posedge clk) begin
    if (reset) begin
        ddr_offset <= DDR_OFFSET_RESET;
    end
    else if (wr_en && offset == CFG_DDR_OFFSET) begin
        ddr_offset <= strb_merge(ddr_offset, pwdata, pstrb);
    end
end

always_ff @(posedge clk) begin
    if (reset) begin
        boot_vec <= BOOT_VEC_RESET;
    end
    else if (wr_en && offset == CFG_BOOT_VEC) begin
        boot_vec <= strb_merge(boot_vec, pwdata, pstrb);
    end
end

// core held in reset until software clears bit 0
always_ff @(posedge clk) begin
    if (reset) begin
        core_reset <= 1'b1;
    end
    else if (wr_en && offset == CFG_CORE_CTRL && pstrb[0]) begin
        core_reset <= pwdata[0];
    end
end

// read mux, unlisted offsets read zero
always_comb begin
    case (offset)
        CFG_DDR_OFFSET: rdata = ddr_offset;
        CFG_BOOT_VEC:   rdata = boot_vec;
        CFG_CORE_CTRL:  rdata = {{(APB_DATA_W-1){1'b0}}, core_reset};
        default:        rdata = '0;
    endcase
end

endmodule

// ==== hw/int_ctrl.sv ====
`timescale 1ns/1ps

module int_ctrl import periph_pkg::*; (
    input                           clk,
    input                           reset,
    input                           sreset,

    // apb slave side, already decoded
    input                           sel,
    input                           penable,
    input                           pwrite,
    input        [OFFSET_W-1:0]     offset,
    input        [APB_STRB_W-1:0]   pstrb,
    input        [APB_DATA_W-1:0]   pwdata,
    output logic [APB_DATA_W-1:0]   rdata,

    // external interrupt lines
    input        [INT_NUM-1:0]      ints,

    // interrupts to the core
    output logic                    msip,
    output logic                    mtip,
    output logic                    meip,
    output logic [TIME_W-1:0]       systime
);

logic                   wr_en;
logic [TIME_W-1:0]      mtime;
logic [TIME_W-1:0]      mtimecmp;
logic [INT_NUM-1:0]     enable;
logic [INT_NUM-1:0]     pending;

assign wr_en   = sel & penable & pwrite;
assign pending = ints & enable;
assign systime = mtime;

// system timer keeps running through warm resets
always_ff @(posedge clk) begin
    if (reset) begin
        mtime <= '0;
    end
    else begin
        mtime <= mtime + 1'b1;
    end
end

// software interrupt
always_ff @(posedge clk) begin
    if (sreset) begin
        msip <= 1'b0;
    end
    else if (wr_en && offset == INTC_MSIP && pstrb[0]) begin
        msip <= pwdata[0];
    end
end

always_ff @(posedge clk) begin
    if (sreset) begin
        enable <= '0;
    end
    else if (wr_en && offset == INTC_ENABLE) begin
        enable <= strb_merge(enable, pwdata, pstrb);
    end
end

// compare value, all ones keeps mtip quiet
always_ff @(posedge clk) begin
    if (sreset) begin
        mtimecmp <= '1;
    end
    else if (wr_en && offset == INTC_MTIMECMP_LO) begin
        mtimecmp[APB_DATA_W-1:0] <= strb_merge(mtimecmp[APB_DATA_W-1:0], pwdata, pstrb);
    end
    else if (wr_en && offset == INTC_MTIMECMP_HI) begin
        mtimecmp[TIME_W-1:APB_DATA_W] <=
            strb_merge(mtimecmp[TIME_W-1:APB_DATA_W], pwdata, pstrb);
    end
end

// registered interrupt levels, one cycle behind their sources
always_ff @(posedge clk) begin
    if (sreset) begin
        mtip <= 1'b0;
        meip <= 1'b0;
    end
    else begin
        mtip <= (mtime >= mtimecmp);
        meip <= |pending;
    end
end

// timer and pending words read live values
always_comb begin
    case (offset)
        INTC_MSIP:        rdata = {{(APB_DATA_W-1){1'b0}}, msip};
        INTC_ENABLE:      rdata = enable;
        INTC_PENDING:     rdata = pending;
        INTC_MTIMECMP_LO: rdata = mtimecmp[APB_DATA_W-1:0];
        INTC_MTIMECMP_HI: rdata = mtimecmp[TIME_W-1:APB_DATA_W];
        INTC_MTIME_LO:    rdata = mtime[APB_DATA_W-1:0];
        INTC_MTIME_HI:    rdata = mtime[TIME_W-1:APB_DATA_W];
        default:          rdata = '0;
    endcase
end

endmodule

// ==== hw/periph_pkg.sv ====
package periph_pkg;

    // apb port
    localparam int APB_ADDR_W = 32;
    localparam int APB_DATA_W = 32;
    localparam int APB_STRB_W = 4;

    // address split, region in paddr[15:12] and register offset in paddr[7:0]
    localparam int REGION_LSB = 12;
    localparam int REGION_W   = 4;
    localparam int OFFSET_W   = 8;

    localparam logic [REGION_W-1:0] REGION_CFG  = 4'd0;
    localparam logic [REGION_W-1:0] REGION_INTC = 4'd1;

    // configuration block
    localparam logic [OFFSET_W-1:0] CFG_DDR_OFFSET = 8'h00;
    localparam logic [OFFSET_W-1:0] CFG_BOOT_VEC   = 8'h04;
    localparam logic [OFFSET_W-1:0] CFG_CORE_CTRL  = 8'h08;

    // interrupt controller
    localparam logic [OFFSET_W-1:0] INTC_MSIP        = 8'h00;
    localparam logic [OFFSET_W-1:0] INTC_ENABLE      = 8'h04;
    localparam logic [OFFSET_W-1:0] INTC_PENDING     = 8'h08;
    localparam logic [OFFSET_W-1:0] INTC_MTIMECMP_LO = 8'h10;
    localparam logic [OFFSET_W-1:0] INTC_MTIMECMP_HI = 8'h14;
    localparam logic [OFFSET_W-1:0] INTC_MTIME_LO    = 8'h18;
    localparam logic [OFFSET_W-1:0] INTC_MTIME_HI    = 8'h1C;

    localparam logic [31:0] BOOT_VEC_RESET   = 32'h0000_1000;
    localparam logic [31:0] DDR_OFFSET_RESET = 32'h0000_0000;

    localparam int TIME_W  = 64;
    localparam int INT_NUM = 32;

    // reset window length and the counter that times it
    localparam int RST_STRETCH = 8;
    localparam int RST_CNT_W   = $clog2(RST_STRETCH + 1);

    // byte lanes of new_word replace those of old_word where strb is set
    function automatic logic [APB_DATA_W-1:0] strb_merge(
        input logic [APB_DATA_W-1:0] old_word,
        input logic [APB_DATA_W-1:0] new_word,
        input logic [APB_STRB_W-1:0] strb
    );
        logic [APB_DATA_W-1:0] merged;
        merged = old_word;
        for (int i = 0; i < APB_STRB_W; i++) begin
            if (strb[i]) begin
                merged[i*8 +: 8] = new_word[i*8 +: 8];
            end
        end
        return merged;
    endfunction

endpackage

// ==== hw/periph_subsys.sv ====
`timescale 1ns/1ps

module periph_subsys import periph_pkg::*; (
    input                           clk,
    input                           reset,

    // debug apb slave port
    input                           psel,
    input                           penable,
    input                           pwrite,
    input        [APB_ADDR_W-1:0]   paddr,
    input        [APB_STRB_W-1:0]   pstrb,
    input        [APB_DATA_W-1:0]   pwdata,
    output logic [APB_DATA_W-1:0]   prdata,
    output logic                    pready,
    output logic                    pslverr,

    // external interrupt lines and warm reset request
    input        [INT_NUM-1:0]      ints,
    input                           warm_rst_trigger,

    // configuration outputs
    output logic [31:0]             ddr_offset,
    output logic [31:0]             boot_vec,

    // reset levels
    output logic                    xreset,
    output logic                    sreset,

    // interrupts and time to the core
    output logic                    msip,
    output logic                    mtip,
    output logic                    meip,
    output logic [TIME_W-1:0]       systime
);

logic                   cfg_sel;
logic                   intc_sel;
logic [OFFSET_W-1:0]    offset;
logic [APB_DATA_W-1:0]  cfg_rdata;
logic [APB_DATA_W-1:0]  intc_rdata;
logic                   core_reset;

apb_decoder u_apb_decoder (
    .psel       ( psel       ),
    .penable    ( penable    ),
    .paddr      ( paddr      ),
    .cfg_rdata  ( cfg_rdata  ),
    .intc_rdata ( intc_rdata ),
    .cfg_sel    ( cfg_sel    ),
    .intc_sel   ( intc_sel   ),
    .offset     ( offset     ),
    .prdata     ( prdata     ),
    .pready     ( pready     ),
    .pslverr    ( pslverr    )
);

cfg_regs u_cfg_regs (
    .clk        ( clk        ),
    .reset      ( reset      ),
    .sel        ( cfg_sel    ),
    .penable    ( penable    ),
    .pwrite     ( pwrite     ),
    .offset     ( offset     ),
    .pstrb      ( pstrb      ),
    .pwdata     ( pwdata     ),
    .rdata      ( cfg_rdata  ),
    .ddr_offset ( ddr_offset ),
    .boot_vec   ( boot_vec   ),
    .core_reset ( core_reset )
);

reset_gen u_reset_gen (
    .clk              ( clk              ),
    .reset            ( reset            ),
    .core_reset       ( core_reset       ),
    .warm_rst_trigger ( warm_rst_trigger ),
    .xreset           ( xreset           ),
    .sreset           ( sreset           )
);

// interrupt registers follow the system reset level
int_ctrl u_int_ctrl (
    .clk        ( clk        ),
    .reset      ( reset      ),
    .sreset     ( sreset     ),
    .sel        ( intc_sel   ),
    .penable    ( penable    ),
    .pwrite     ( pwrite     ),
    .offset     ( offset     ),
    .pstrb      ( pstrb      ),
    .pwdata     ( pwdata     ),
    .rdata      ( intc_rdata ),
    .ints       ( ints       ),
    .msip       ( msip       ),
    .mtip       ( mtip       ),
    .meip       ( meip       ),
    .systime    ( systime    )
);

endmodule

// ==== hw/reset_gen.sv ====
`timescale 1ns/1ps

module reset_gen import periph_pkg::*; (
    input                           clk,
    input                           reset,
    input                           core_reset,
    input                           warm_rst_trigger,

    output logic                    xreset,
    output logic                    sreset
);

logic [RST_CNT_W-1:0] rel_cnt;
logic [RST_CNT_W-1:0] warm_cnt;

// release counter
// held full while either reset source is high, then counts down
always_ff @(posedge clk) begin
    if (reset || core_reset) begin
        rel_cnt <= RST_CNT_W'(RST_STRETCH);
    end
    else if (rel_cnt != '0) begin
        rel_cnt <= rel_cnt - 1'b1;
    end
end

// warm reset window, loaded by the trigger pulse
always_ff @(posedge clk) begin
    if (reset) begin
        warm_cnt <= '0;
    end
    else if (warm_rst_trigger) begin
        warm_cnt <= RST_CNT_W'(RST_STRETCH);
    end
    else if (warm_cnt != '0) begin
        warm_cnt <= warm_cnt - 1'b1;
    end
end

// both levels come straight off the counters, no decode glitches
assign xreset = (rel_cnt != '0);
assign sreset = (rel_cnt != '0) | (warm_cnt != '0);

endmodule

// ==== src.f ====
hw/periph_pkg.sv
hw/apb_decoder.sv
hw/cfg_regs.sv
hw/reset_gen.sv
hw/int_ctrl.sv
hw/periph_subsys.sv
testbench/periph_subsys_tb.sv

// ==== testbench/periph_subsys_tb.sv ====
`timescale 1ns/1ps

module periph_subsys_tb import periph_pkg::*; ();

localparam logic [APB_ADDR_W-1:0] CFG_BASE  = APB_ADDR_W'(REGION_CFG) << REGION_LSB;
localparam logic [APB_ADDR_W-1:0] INTC_BASE = APB_ADDR_W'(REGION_INTC) << REGION_LSB;
localparam logic [APB_ADDR_W-1:0] BAD_BASE  = APB_ADDR_W'(2) << REGION_LSB;

// one apb transfer with its expected response
typedef struct packed {
    logic        wr;
    logic [31:0] addr;
    logic [3:0]  strb;
    logic [31:0] wdata;
    logic [31:0] exp_data;
    logic [31:0] dc_mask;
    logic        exp_err;
} row_t;

row_t               rows[$];
int                 phase2_start;
bit                 table_ready;
int                 error_count;
integer             seed;
logic [TIME_W-1:0]  sampled_time;
logic [31:0]        ddr_expect;
logic [31:0]        boot_expect;

logic                   clk;
logic                   reset;
logic                   psel;
logic                   penable;
logic                   pwrite;
logic [APB_ADDR_W-1:0]  paddr;
logic [APB_STRB_W-1:0]  pstrb;
logic [APB_DATA_W-1:0]  pwdata;
logic [APB_DATA_W-1:0]  prdata;
logic                   pready;
logic                   pslverr;
logic [INT_NUM-1:0]     ints;
logic                   warm_rst_trigger;
logic [31:0]            ddr_offset;
logic [31:0]            boot_vec;
logic                   xreset;
logic                   sreset;
logic                   msip;
logic                   mtip;
logic                   meip;
logic [TIME_W-1:0]      systime;

periph_subsys periph_subsys_i (
    .clk              ( clk              ),
    .reset            ( reset            ),
    .psel             ( psel             ),
    .penable          ( penable          ),
    .pwrite           ( pwrite           ),
    .paddr            ( paddr            ),
    .pstrb            ( pstrb            ),
    .pwdata           ( pwdata           ),
    .prdata           ( prdata           ),
    .pready           ( pready           ),
    .pslverr          ( pslverr          ),
    .ints             ( ints             ),
    .warm_rst_trigger ( warm_rst_trigger ),
    .ddr_offset       ( ddr_offset       ),
    .boot_vec         ( boot_vec         ),
    .xreset           ( xreset           ),
    .sreset           ( sreset           ),
    .msip             ( msip             ),
    .mtip             ( mtip             ),
    .meip             ( meip             ),
    .systime          ( systime          )
);

always #2 clk = ~clk;

// expected word after a strobed write
function automatic logic [31:0] strobed(input logic [31:0] old_v, input logic [31:0] new_v,
                                        input logic [3:0] strb);
    logic [31:0] lanes;
    lanes = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    return (old_v & ~lanes) | (new_v & lanes);
endfunction

task automatic flag_error(input string msg);
    error_count++;
    $display("[ERROR] %0t: %s", $time, msg);
endtask

task automatic add_row(input logic wr, input logic [31:0] addr, input logic [3:0] strb,
                       input logic [31:0] wdata, input logic [31:0] exp_data,
                       input logic [31:0] dc_mask, input logic exp_err);
    row_t r;
    r.wr       = wr;
    r.addr     = addr;
    r.strb     = strb;
    r.wdata    = wdata;
    r.exp_data = exp_data;
    r.dc_mask  = dc_mask;
    r.exp_err  = exp_err;
    rows.push_back(r);
endtask

// setup cycle, access cycle, sample in the middle of the access cycle
task automatic apb_xfer(input logic wr, input logic [31:0] addr, input logic [3:0] strb,
                        input logic [31:0] wdata, output logic [31:0] rdata,
                        output logic err);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pstrb   <= strb;
    pwdata  <= wdata;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    if (pready !== 1'b1) begin
        flag_error($sformatf("pready low in access cycle at 0x%08h", addr));
    end
    rdata        = prdata;
    err          = pslverr;
    sampled_time = systime;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
endtask

task automatic read_expect(input logic [31:0] addr, input logic [31:0] exp_data,
                           input string what);
    logic [31:0] rdata;
    logic        err;
    apb_xfer(1'b0, addr, 4'h0, 32'h0, rdata, err);
    if (rdata !== exp_data || err !== 1'b0) begin
        flag_error($sformatf("%s read 0x%08h err %b, expected 0x%08h", what, rdata, err,
                             exp_data));
    end
endtask

task automatic build_table();
    logic [31:0] rnd;
    // reset values
    // mtime has counted only a few dozen cycles here, so only its low byte may vary
    add_row(0, CFG_BASE + CFG_DDR_OFFSET, 0, 0, DDR_OFFSET_RESET, 0, 0);
    add_row(0, CFG_BASE + CFG_BOOT_VEC, 0, 0, BOOT_VEC_RESET, 0, 0);
    add_row(0, CFG_BASE + CFG_CORE_CTRL, 0, 0, 32'h1, 0, 0);
    add_row(0, INTC_BASE + INTC_MSIP, 0, 0, 32'h0, 0, 0);
    add_row(0, INTC_BASE + INTC_ENABLE, 0, 0, 32'h0, 0, 0);
    add_row(0, INTC_BASE + INTC_PENDING, 0, 0, 32'h0, 0, 0);
    add_row(0, INTC_BASE + INTC_MTIMECMP_LO, 0, 0, 32'hffff_ffff, 0, 0);
    add_row(0, INTC_BASE + INTC_MTIMECMP_HI, 0, 0, 32'hffff_ffff, 0, 0);
    add_row(0, INTC_BASE + INTC_MTIME_LO, 0, 0, 32'h0, 32'h0000_00ff, 0);
    add_row(0, INTC_BASE + INTC_MTIME_HI, 0, 0, 32'h0, 0, 0);
    ddr_expect  = DDR_OFFSET_RESET;
    boot_expect = BOOT_VEC_RESET;
    // partial strobe writes
    rnd = $random(seed);
    ddr_expect = strobed(ddr_expect, rnd, 4'b0101);
    add_row(1, CFG_BASE + CFG_DDR_OFFSET, 4'b0101, rnd, 0, '1, 0);
    add_row(0, CFG_BASE + CFG_DDR_OFFSET, 0, 0, ddr_expect, 0, 0);
    rnd = $random(seed);
    boot_expect = strobed(boot_expect, rnd, 4'b1010);
    add_row(1, CFG_BASE + CFG_BOOT_VEC, 4'b1010, rnd, 0, '1, 0);
    add_row(0, CFG_BASE + CFG_BOOT_VEC, 0, 0, boot_expect, 0, 0);
    rnd = $random(seed);
    ddr_expect = strobed(ddr_expect, rnd, 4'b1000);
    add_row(1, CFG_BASE + CFG_DDR_OFFSET, 4'b1000, rnd, 0, '1, 0);
    add_row(0, CFG_BASE + CFG_DDR_OFFSET, 0, 0, ddr_expect, 0, 0);
    // unmapped region and unlisted offset
    add_row(0, BAD_BASE, 0, 0, 32'h0, 0, 1);
    add_row(1, BAD_BASE, 4'hf, $random(seed), 32'h0, 0, 1);
    add_row(1, CFG_BASE + 32'h0C, 4'hf, $random(seed), 0, '1, 0);
    add_row(0, CFG_BASE + 32'h0C, 0, 0, 32'h0, 0, 0);
    add_row(0, CFG_BASE + CFG_DDR_OFFSET, 0, 0, ddr_expect, 0, 0);
    add_row(0, CFG_BASE + CFG_BOOT_VEC, 0, 0, boot_expect, 0, 0);
    add_row(0, CFG_BASE + CFG_CORE_CTRL, 0, 0, 32'h1, 0, 0);
    phase2_start = rows.size();
    // after the warm reset
    add_row(0, INTC_BASE + INTC_MSIP, 0, 0, 32'h0, 0, 0);
    add_row(0, INTC_BASE + INTC_ENABLE, 0, 0, 32'h0, 0, 0);
    add_row(0, INTC_BASE + INTC_MTIMECMP_LO, 0, 0, 32'hffff_ffff, 0, 0);
    add_row(0, INTC_BASE + INTC_MTIMECMP_HI, 0, 0, 32'hffff_ffff, 0, 0);
    add_row(1, INTC_BASE + 32'h20, 4'hf, $random(seed), 0, '1, 0);
    add_row(0, INTC_BASE + 32'h20, 0, 0, 32'h0, 0, 0);
    add_row(0, INTC_BASE + INTC_ENABLE, 0, 0, 32'h0, 0, 0);
    add_row(0, CFG_BASE + CFG_DDR_OFFSET, 0, 0, ddr_expect, 0, 0);
    add_row(0, CFG_BASE + CFG_BOOT_VEC, 0, 0, boot_expect, 0, 0);
    add_row(0, CFG_BASE + CFG_CORE_CTRL, 0, 0, 32'h0, 0, 0);
endtask

task automatic run_rows(input int first, input int last);
    logic [31:0] rdata;
    logic        err;
    for (int i = first; i < last; i++) begin
        apb_xfer(rows[i].wr, rows[i].addr, rows[i].strb, rows[i].wdata, rdata, err);
        if (((rdata ^ rows[i].exp_data) & ~rows[i].dc_mask) !== 32'h0) begin
            flag_error($sformatf("row %0d at 0x%08h read 0x%08h, expected 0x%08h", i,
                                 rows[i].addr, rdata, rows[i].exp_data));
        end
        if (err !== rows[i].exp_err) begin
            flag_error($sformatf("row %0d at 0x%08h pslverr %b, expected %b", i,
                                 rows[i].addr, err, rows[i].exp_err));
        end
    end
endtask

task automatic release_core();
    logic [31:0] rdata;
    logic        err;
    int          cycles;
    apb_xfer(1'b1, CFG_BASE + CFG_CORE_CTRL, 4'hf, 32'h0, rdata, err);
    cycles = 0;
    @(negedge clk);
    while (xreset === 1'b1 && cycles < 4 * RST_STRETCH) begin
        if (sreset !== 1'b1) begin
            flag_error("sreset low while xreset still high");
        end
        cycles++;
        @(negedge clk);
    end
    if (cycles != RST_STRETCH) begin
        flag_error($sformatf("xreset fell after %0d cycles, expected %0d", cycles, RST_STRETCH));
    end
    if (sreset !== 1'b0) begin
        flag_error("sreset did not fall with xreset");
    end
endtask

task automatic interrupt_checks();
    logic [31:0] rdata;
    logic        err;
    logic [31:0] en;
    logic [31:0] val;
    logic        prev;
    apb_xfer(1'b1, INTC_BASE + INTC_MSIP, 4'h1, 32'h1, rdata, err);
    @(negedge clk);
    if (msip !== 1'b1) begin
        flag_error("msip not raised by write to INTC_MSIP");
    end
    en = $random(seed);
    apb_xfer(1'b1, INTC_BASE + INTC_ENABLE, 4'hf, en, rdata, err);
    prev = 1'b0;
    // last round drives all lines low
    for (int k = 0; k < 3; k++) begin
        val = (k == 2) ? 32'h0 : $random(seed);
        @(posedge clk);
        ints <= val;
        @(negedge clk);
        if (meip !== prev) begin
            flag_error("meip changed before its one-cycle delay");
        end
        @(negedge clk);
        if (meip !== |(val & en)) begin
            flag_error($sformatf("meip %b with ints 0x%08h enable 0x%08h", meip, val, en));
        end
        prev = |(val & en);
        read_expect(INTC_BASE + INTC_PENDING, val & en, "INTC_PENDING");
    end
endtask

task automatic timer_checks();
    logic [31:0]       first;
    logic [31:0]       second;
    logic [31:0]       rdata;
    logic              err;
    logic [TIME_W-1:0] target;
    int                waited;
    apb_xfer(1'b0, INTC_BASE + INTC_MTIME_LO, 4'h0, 32'h0, first, err);
    if (first !== sampled_time[31:0]) begin
        flag_error($sformatf("mtime_lo 0x%08h but systime 0x%0h", first, sampled_time));
    end
    apb_xfer(1'b0, INTC_BASE + INTC_MTIME_LO, 4'h0, 32'h0, second, err);
    if (second !== sampled_time[31:0]) begin
        flag_error($sformatf("mtime_lo 0x%08h but systime 0x%0h", second, sampled_time));
    end
    if (second <= first) begin
        flag_error($sformatf("mtime did not increase, 0x%08h then 0x%08h", first, second));
    end
    target = sampled_time + 50;
    // high half first so the compare never passes through a small value
    apb_xfer(1'b1, INTC_BASE + INTC_MTIMECMP_HI, 4'hf, target[63:32], rdata, err);
    apb_xfer(1'b1, INTC_BASE + INTC_MTIMECMP_LO, 4'hf, target[31:0], rdata, err);
    @(negedge clk);
    if (mtip !== 1'b0) begin
        flag_error("mtip high before mtime reached mtimecmp");
    end
    waited = 0;
    while (mtip !== 1'b1 && waited < 60) begin
        @(negedge clk);
        waited++;
    end
    if (mtip !== 1'b1) begin
        flag_error("mtip did not rise within 60 cycles");
    end
    else if (systime <= target) begin
        flag_error($sformatf("mtip rose at time 0x%0h, compare 0x%0h", systime, target));
    end
    apb_xfer(1'b1, INTC_BASE + INTC_MTIMECMP_HI, 4'hf, 32'hffff_ffff, rdata, err);
    apb_xfer(1'b1, INTC_BASE + INTC_MTIMECMP_LO, 4'hf, 32'hffff_ffff, rdata, err);
    @(negedge clk);
    if (mtip !== 1'b0) begin
        flag_error("mtip not cleared by all-ones mtimecmp");
    end
endtask

task automatic warm_reset_checks();
    logic [31:0] rdata;
    logic        err;
    int          cycles;
    // raise meip and move mtimecmp off its reset value, still far above mtime
    @(posedge clk);
    ints <= '1;
    apb_xfer(1'b1, INTC_BASE + INTC_MTIMECMP_LO, 4'hf, 32'h0, rdata, err);
    @(posedge clk);
    warm_rst_trigger <= 1'b1;
    @(negedge clk);
    if (sreset !== 1'b0) begin
        flag_error("sreset high in the trigger cycle");
    end
    @(posedge clk);
    warm_rst_trigger <= 1'b0;
    cycles = 0;
    @(negedge clk);
    while (sreset === 1'b1 && cycles < 4 * RST_STRETCH) begin
        if (xreset !== 1'b0) begin
            flag_error("xreset raised by warm reset");
        end
        cycles++;
        @(negedge clk);
    end
    if (cycles != RST_STRETCH) begin
        flag_error($sformatf("sreset window %0d cycles, expected %0d", cycles, RST_STRETCH));
    end
    if (msip !== 1'b0 || mtip !== 1'b0 || meip !== 1'b0) begin
        flag_error("interrupt lines not cleared by warm reset");
    end
endtask

initial begin
    int limit;
    wait (table_ready);
    limit = rows.size() * 4 + 400;
    repeat (limit) @(posedge clk);
    $display("timeout, the test did not finish within %0d cycles", limit);
    $display("** FAIL **");
    $finish;
end

initial begin
    clk              = 1'b0;
    reset            = 1'b1;
    psel             = 1'b0;
    penable          = 1'b0;
    pwrite           = 1'b0;
    paddr            = '0;
    pstrb            = '0;
    pwdata           = '0;
    ints             = '0;
    warm_rst_trigger = 1'b0;
    error_count      = 0;
    seed             = 32'h394e;
    build_table();
    table_ready = 1'b1;
    repeat (16) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    if (xreset !== 1'b1 || sreset !== 1'b1) begin
        flag_error("xreset and sreset not both high after reset");
    end
    if (msip !== 1'b0 || mtip !== 1'b0 || meip !== 1'b0) begin
        flag_error("interrupt lines not low after reset");
    end
    run_rows(0, phase2_start);
    if (ddr_offset !== ddr_expect || boot_vec !== boot_expect) begin
        flag_error($sformatf("ddr_offset 0x%08h boot_vec 0x%08h, expected 0x%08h 0x%08h",
                             ddr_offset, boot_vec, ddr_expect, boot_expect));
    end
    release_core();
    interrupt_checks();
    timer_checks();
    warm_reset_checks();
    run_rows(phase2_start, rows.size());
    $display("checks done, %0d errors", error_count);
    if (error_count == 0) begin
        $display("** PASS **");
    end
    else begin
        $display("** FAIL **");
    end
    $finish;
end

endmodule
